// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	////////////////////
	// Address map and cache geometry

	localparam logic [31:0] reset_vector = 32'h3000_0000;

	localparam int line_words = 8;
	localparam int line_count = 16;

	localparam int offset_bits = 3;  // Word within a line
	localparam int index_bits  = 4;
	localparam int tag_bits    = 23;

	localparam int offset_lsb = 2;
	localparam int index_lsb  = offset_lsb + offset_bits;
	localparam int tag_lsb    = index_lsb + index_bits;

	localparam int perf_bits = 16;

	localparam logic [1:0] resp_okay = 2'b00;

	////////////////////
	// Encodings

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01,
		burst_wrap  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		state_lookup,
		state_request,
		state_receive,
		state_deliver   // Last refill word lands in the cache
	} fetch_state_e;

	////////////////////
	// Channel payloads

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  len;
		burst_e      burst;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} axi_r_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_out_t;

	// One beat into the cache data array
	typedef struct packed {
		logic        en;
		logic [31:0] addr;
		logic [31:0] data;
		logic        last;
	} refill_wr_t;

	typedef struct packed {
		logic [perf_bits-1:0] hits;
		logic [perf_bits-1:0] misses;
		logic [perf_bits-1:0] redirects;
	} fetch_perf_t;

endpackage

`default_nettype wire

// File: hdl/icache.sv
`default_nettype none

module icache import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] lookup_addr,
	output logic        hit,
	output logic [31:0] hit_data,
	input  refill_wr_t  refill
);

	logic [tag_bits-1:0]    tag_array [line_count];
	logic [31:0]            data_array [line_count][line_words];
	logic [line_count-1:0]  valid_bits;

	logic [offset_bits-1:0] lookup_offset;
	logic [index_bits-1:0]  lookup_index;
	logic [tag_bits-1:0]    lookup_tag;

	logic [offset_bits-1:0] refill_offset;
	logic [index_bits-1:0]  refill_index;
	logic [tag_bits-1:0]    refill_tag;

	logic                   burst_open;
	logic [index_bits-1:0]  burst_index;

	////////////////////
	// Lookup

	assign lookup_offset = lookup_addr[offset_lsb +: offset_bits];
	assign lookup_index  = lookup_addr[index_lsb +: index_bits];
	assign lookup_tag    = lookup_addr[tag_lsb +: tag_bits];

	assign hit      = valid_bits[lookup_index] && tag_array[lookup_index] == lookup_tag;
	assign hit_data = data_array[lookup_index][lookup_offset];

	////////////////////
	// Refill

	assign refill_offset = refill.addr[offset_lsb +: offset_bits];
	assign refill_index  = refill.addr[index_lsb +: index_bits];
	assign refill_tag    = refill.addr[tag_lsb +: tag_bits];

	// Line is invalid while it is half overwritten
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (refill.en) begin
			valid_bits[refill_index] <= refill.last;
		end
	end

	always_ff @(posedge clock) begin
		if (refill.en) begin
			data_array[refill_index][refill_offset] <= refill.data;
			if (refill.last)
				tag_array[refill_index] <= refill_tag;  // Tag goes in with the final word
		end
	end

	////////////////////
	// Burst tracking

	always_ff @(posedge clock) begin
		if (reset) begin
			burst_open <= 1'b0;
		end else if (refill.en) begin
			burst_open <= !refill.last;
		end
	end

	always_ff @(posedge clock) begin
		if (refill.en)
			burst_index <= refill_index;
	end

	// All beats of one refill go to the same line
	same_index_a: assert property (@(posedge clock) disable iff (reset)
		refill.en && burst_open |-> refill_index == burst_index);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  logic         clock,
	input  logic         reset,

	output logic         ar_valid,
	output axi_ar_t      ar,
	input  logic         ar_ready,
	input  logic         r_valid,
	input  axi_r_t       r,

	output logic [31:0]  lookup_addr,
	input  logic         hit,
	input  logic [31:0]  hit_data,
	output refill_wr_t   refill,

	input  logic         redirect,
	input  logic [31:0]  redirect_pc,

	output logic         out_valid,
	output fetch_out_t   out,
	input  logic         out_ready,

	output logic         hit_event,
	output logic         miss_event
);

	fetch_state_e state;
	logic [31:0]  pc;
	logic [31:0]  beat_addr;
	logic         redirect_pending;

	logic         refill_en;
	logic [31:0]  refill_addr;
	logic [31:0]  refill_data;
	logic         refill_last;

	logic         r_ready;
	logic         out_free;
	logic         lookup_go;
	logic         beat;
	logic         beat_match;

	assign r_ready     = 1'b1;
	assign lookup_addr = pc;

	assign out_free   = !out_valid || out_ready;  // Output register empty or draining
	assign lookup_go  = state == state_lookup && !redirect && out_free;
	assign hit_event  = lookup_go && hit;
	assign miss_event = lookup_go && !hit;

	assign beat       = state == state_receive && r_valid && r_ready;
	assign beat_match = beat_addr[offset_lsb +: offset_bits] == out.pc[offset_lsb +: offset_bits];

	// out.pc holds the missing pc for the whole burst
	assign ar = '{
		addr:  {out.pc[31:index_lsb], {index_lsb{1'b0}}},
		len:   4'(line_words - 1),
		burst: burst_incr
	};

	assign refill = '{en: refill_en, addr: refill_addr, data: refill_data, last: refill_last};

	////////////////////
	// Control

	always_ff @(posedge clock) begin
		if (reset) begin
			state            <= state_lookup;
			pc               <= reset_vector;
			ar_valid         <= 1'b0;
			out_valid        <= 1'b0;
			redirect_pending <= 1'b0;
			refill_en        <= 1'b0;
		end else begin
			refill_en <= beat;

			if (out_valid && out_ready)
				out_valid <= 1'b0;

			case (state)
				state_lookup: begin
					if (redirect) begin
						out_valid <= 1'b0;  // Drop whatever is waiting
						pc        <= redirect_pc;
					end else if (out_free) begin
						if (hit) begin
							out_valid <= 1'b1;
							pc        <= pc + 32'd4;
						end else begin
							ar_valid <= 1'b1;
							state    <= state_request;
						end
					end
				end

				state_request, state_receive: begin
					// Burst runs to the end, its item is dropped
					if (redirect) begin
						pc               <= redirect_pc;
						redirect_pending <= 1'b1;
					end
					if (ar_valid && ar_ready) begin
						ar_valid <= 1'b0;
						state    <= state_receive;
					end
					if (beat && r.last) begin
						state            <= state_deliver;
						redirect_pending <= 1'b0;
						if (!redirect && !redirect_pending) begin
							out_valid <= 1'b1;
							pc        <= pc + 32'd4;
						end
					end
				end

				state_deliver: begin
					if (redirect) begin
						out_valid <= 1'b0;
						pc        <= redirect_pc;
					end
					state <= state_lookup;
				end

				default: state <= state_lookup;
			endcase
		end
	end

	////////////////////
	// Payload

	always_ff @(posedge clock) begin
		if (lookup_go) begin
			out.pc    <= pc;
			beat_addr <= {pc[31:index_lsb], {index_lsb{1'b0}}};
			if (hit)
				out.inst <= hit_data;
		end
		if (beat) begin
			beat_addr   <= beat_addr + 32'd4;
			refill_addr <= beat_addr;
			refill_data <= r.data;
			refill_last <= r.last;
			if (beat_match)
				out.inst <= r.data;  // Missing word taken in flight
		end
	end

	////////////////////
	// Checks

	ar_hold_a: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar));

	out_hold_a: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect |=> out_valid && $stable(out));

	// Line-aligned burst, so the beat offset counts beats
	last_beat_a: assert property (@(posedge clock) disable iff (reset)
		beat |-> r.last == (beat_addr[offset_lsb +: offset_bits] == offset_bits'(line_words - 1)));

	resp_okay_a: assert property (@(posedge clock) disable iff (reset)
		beat |-> r.resp == resp_okay);

endmodule

`default_nettype wire

// File: hdl/fetch_perf.sv
`default_nettype none

module fetch_perf import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        hit_event,
	input  logic        miss_event,
	input  logic        redirect,
	output fetch_perf_t perf
);

	// Sticks at all ones
	function automatic logic [perf_bits-1:0] bump(
		input logic [perf_bits-1:0] count,
		input logic                 fire
	);
		if (fire && count != '1)
			return count + 1'b1;
		return count;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			perf <= '0;
		end else begin
			perf.hits      <= bump(perf.hits, hit_event);
			perf.misses    <= bump(perf.misses, miss_event);
			perf.redirects <= bump(perf.redirects, redirect);
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic        clock,
	input  logic        reset,

	output logic        ar_valid,
	output axi_ar_t     ar,
	input  logic        ar_ready,
	input  logic        r_valid,
	input  axi_r_t      r,

	input  logic        redirect,
	input  logic [31:0] redirect_pc,

	output logic        out_valid,
	output fetch_out_t  out,
	input  logic        out_ready,

	output fetch_perf_t perf
);

	logic [31:0] lookup_addr;
	logic        hit;
	logic [31:0] hit_data;
	refill_wr_t  refill;
	logic        hit_event;
	logic        miss_event;

	fetch_unit fetch_unit_i (
		.clock       (clock),
		.reset       (reset),
		.ar_valid    (ar_valid),
		.ar          (ar),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r           (r),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_data    (hit_data),
		.refill      (refill),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.out_valid   (out_valid),
		.out         (out),
		.out_ready   (out_ready),
		.hit_event   (hit_event),
		.miss_event  (miss_event)
	);

	icache icache_i (
		.clock       (clock),
		.reset       (reset),
		.lookup_addr (lookup_addr),
		.hit         (hit),
		.hit_data    (hit_data),
		.refill      (refill)
	);

	fetch_perf fetch_perf_i (
		.clock      (clock),
		.reset      (reset),
		.hit_event  (hit_event),
		.miss_event (miss_event),
		.redirect   (redirect),
		.perf       (perf)
	);

endmodule

`default_nettype wire

// File: dv/axi_burst_mem.sv
`default_nettype none

module axi_burst_mem import fetch_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    ar_valid,
	input  axi_ar_t ar,
	output logic    ar_ready,
	output logic    r_valid,
	output axi_r_t  r
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] beat_addr;
	int          beats_left;
	logic        addr_done;
	logic        beat_done;

	// Word contents follow the byte address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'hc0de_0000;
	endfunction

	initial begin
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r          = '0;
		beats_left = 0;
		beat_addr  = '0;
		addr_done  = 1'b0;
		beat_done  = 1'b0;
		forever begin
			@(posedge clock);
			addr_done = ar_valid && ar_ready;  // r_ready is always high
			beat_done = r_valid;
			if (addr_done)
				beat_addr = ar.addr;
			#1;
			if (reset) begin
				ar_ready   = 1'b0;
				r_valid    = 1'b0;
				beats_left = 0;
			end else begin
				if (addr_done) begin
					ar_ready   = 1'b0;
					beats_left = line_words;
				end
				if (beat_done) begin
					r_valid    = 1'b0;
					beats_left = beats_left - 1;
					beat_addr  = beat_addr + 32'd4;
				end

				////////////////////
				// Random stalls

				if (beats_left == 0 && ar_valid && !ar_ready && !addr_done)
					ar_ready = $urandom_range(0, 2) == 0;
				if (beats_left > 0 && $urandom_range(0, 2) != 0) begin
					r_valid = 1'b1;
					r.data  = word_at(beat_addr);
					r.resp  = resp_okay;
					r.last  = beats_left == 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic        clock;
	logic        reset;
	logic        ar_valid;
	axi_ar_t     ar;
	logic        ar_ready;
	logic        r_valid;
	axi_r_t      r;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        out_valid;
	fetch_out_t  out;
	logic        out_ready;
	fetch_perf_t perf;

	// Reference model
	logic [31:0]          exp_pc;
	logic [15:0]          exp_hits;
	logic [15:0]          exp_misses;
	logic [15:0]          exp_redirects;
	int                   xfer_count;
	logic                 skip_class;
	logic                 preclass;
	logic                 count_check;
	logic [tag_bits-1:0]  model_tag [line_count];
	logic [line_count-1:0] model_valid;

	fetch_top dut_i (
		.clock       (clock),
		.reset       (reset),
		.ar_valid    (ar_valid),
		.ar          (ar),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r           (r),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.out_valid   (out_valid),
		.out         (out),
		.out_ready   (out_ready),
		.perf        (perf)
	);

	axi_burst_mem mem_i (
		.clock    (clock),
		.reset    (reset),
		.ar_valid (ar_valid),
		.ar       (ar),
		.ar_ready (ar_ready),
		.r_valid  (r_valid),
		.r        (r)
	);

	always #4 clock = ~clock;

	task fail_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
		$display("FAILED %s expected %h actual %h", name, expected, actual);
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Regression failed");
		$fatal(1, "stopping on timeout");
	endtask

	// Predict hit or miss from the tag copy
	task classify_fetch(input logic [31:0] pc);
		logic [index_bits-1:0] idx;
		logic [tag_bits-1:0]   tag;
		idx = pc[index_lsb +: index_bits];
		tag = pc[tag_lsb +: tag_bits];
		if (model_valid[idx] && model_tag[idx] == tag) begin
			exp_hits <= exp_hits + 1'b1;
		end else begin
			exp_misses       <= exp_misses + 1'b1;
			model_tag[idx]   <= tag;
			model_valid[idx] <= 1'b1;
		end
	endtask

	always @(posedge clock) begin
		if (reset) begin
			exp_pc        <= reset_vector;
			exp_hits      <= '0;
			exp_misses    <= '0;
			exp_redirects <= '0;
			xfer_count    <= 0;
			skip_class    <= 1'b0;
			model_valid   <= '0;
		end else begin
			if (out_valid && out_ready) begin
				xfer_count <= xfer_count + 1;
				exp_pc     <= exp_pc + 32'd4;
				if (skip_class)
					skip_class <= 1'b0;  // Held item was counted already
				else
					classify_fetch(exp_pc);
			end
			if (preclass) begin
				classify_fetch(exp_pc);
				skip_class <= 1'b1;
			end
			if (redirect) begin
				exp_pc        <= redirect_pc;  // After any transfer this cycle
				exp_redirects <= exp_redirects + 1'b1;
			end
		end
	end

	////////////////////
	// Checks

	pc_a: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_ready |-> out.pc == exp_pc)
		else fail_value("pc order", $sampled(exp_pc), $sampled(out.pc));

	inst_a: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_ready |-> out.inst == (out.pc ^ 32'hc0de_0000))
		else fail_value("inst", $sampled(out.pc) ^ 32'hc0de_0000, $sampled(out.inst));

	hold_a: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !redirect |=> out_valid && out == $past(out))
		else fail_value("out hold", $past(out), out);

	ar_addr_a: assert property (@(posedge clock) disable iff (reset)
		$rose(ar_valid) |-> ar.addr == {exp_pc[31:index_lsb], {index_lsb{1'b0}}})
		else fail_value("ar addr", {$sampled(exp_pc[31:index_lsb]), 5'b0}, $sampled(ar.addr));

	ar_format_a: assert property (@(posedge clock) disable iff (reset)
		ar_valid |-> ar.len == 4'd7 && ar.burst == burst_incr)
		else fail_value("ar format", {4'd7, burst_incr}, {$sampled(ar.len), $sampled(ar.burst)});

	ar_hold_a: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && ar == $past(ar))
		else fail_value("ar hold", $past(ar), ar);

	redirects_a: assert property (@(posedge clock) disable iff (reset)
		perf.redirects == exp_redirects)
		else fail_value("redirect count", $sampled(exp_redirects), $sampled(perf.redirects));

	hits_a: assert property (@(posedge clock) disable iff (reset)
		count_check |-> perf.hits == exp_hits)
		else fail_value("hit count", $sampled(exp_hits), $sampled(perf.hits));

	misses_a: assert property (@(posedge clock) disable iff (reset)
		count_check |-> perf.misses == exp_misses)
		else fail_value("miss count", $sampled(exp_misses), $sampled(perf.misses));

	////////////////////
	// Stimulus

	task step_cycle;
		@(posedge clock);
		#1;
	endtask

	task wait_out_valid(input int limit);
		int i;
		for (i = 0; i < limit && !out_valid; i++)
			step_cycle;
		if (!out_valid)
			fail_timeout("out_valid");
	endtask

	task wait_ar_valid(input int limit);
		int i;
		for (i = 0; i < limit && !ar_valid; i++)
			step_cycle;
		if (!ar_valid)
			fail_timeout("ar_valid of a refill burst");
	endtask

	task pulse_redirect(input logic [31:0] target);
		redirect    = 1'b1;
		redirect_pc = target;
		step_cycle;
		redirect    = 1'b0;
	endtask

	// Strobe in a transfer cycle, so no lookup is lost
	task redirect_on_transfer(input logic [31:0] target);
		wait_out_valid(2000);
		pulse_redirect(target);
	endtask

	// Optional random ready and random redirects
	task run_stream(input int count, input bit random_ready, input int redirect_odds);
		int target;
		int i;
		target = xfer_count + count;
		for (i = 0; i < 20000 && xfer_count < target; i++) begin
			if (random_ready)
				out_ready = $urandom_range(0, 1);
			redirect = redirect_odds != 0 && $urandom_range(0, redirect_odds - 1) == 0;
			redirect_pc = reset_vector + ($urandom_range(0, 1023) << 2);
			step_cycle;
		end
		redirect  = 1'b0;
		out_ready = 1'b1;
		if (xfer_count < target)
			fail_timeout("fetched items of a stream");
	endtask

	// Stall decode so the lookups stop, then compare counters
	task check_counts;
		out_ready = 1'b0;
		wait_out_valid(2000);
		preclass = 1'b1;
		step_cycle;
		preclass    = 1'b0;
		count_check = 1'b1;
		step_cycle;
		count_check = 1'b0;
		out_ready   = 1'b1;
	endtask

	initial begin
		void'($urandom(32'hdb2b1533));
		clock       = 1'b0;
		reset       = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		out_ready   = 1'b1;
		preclass    = 1'b0;
		count_check = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		// Sequential stream over five lines
		run_stream(40, 1'b0, 0);
		check_counts;

		// Revisit lines, with one conflict at index 0
		redirect_on_transfer(reset_vector);
		run_stream(20, 1'b0, 0);
		redirect_on_transfer(reset_vector + 32'h200);
		run_stream(10, 1'b0, 0);
		redirect_on_transfer(reset_vector);
		run_stream(12, 1'b0, 0);
		redirect_on_transfer(reset_vector + 32'h40);
		run_stream(8, 1'b0, 0);
		check_counts;

		// Random decode stalls
		run_stream(60, 1'b1, 0);
		check_counts;

		// Redirect in a hit stream
		redirect_on_transfer(reset_vector + 32'h20);
		run_stream(4, 1'b0, 0);
		pulse_redirect(reset_vector + 32'h8);
		run_stream(6, 1'b0, 0);

		// Redirect during an outstanding burst
		pulse_redirect(32'h3000_1000);
		wait_ar_valid(2000);
		pulse_redirect(reset_vector);
		run_stream(4, 1'b0, 0);

		// Redirect while an item is held
		out_ready = 1'b0;
		wait_out_valid(2000);
		pulse_redirect(reset_vector + 32'h60);
		out_ready = 1'b1;
		run_stream(4, 1'b0, 0);

		// Mixed random traffic
		run_stream(150, 1'b1, 12);
		repeat (4) step_cycle;

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_top.f
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/fetch_unit.sv
hdl/fetch_perf.sv
hdl/fetch_top.sv
dv/axi_burst_mem.sv
dv/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_tb \
	--Mdir build \
	-o fetch_sim \
	-f fetch_top.f

./build/fetch_sim 2>&1 | tee sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
else
	exit 1
fi
